//--- include/acq_macros.svh
////////////////////////////////////////////////////////////
// acquisition buffer constants
// sample RAM, stream and system bus widths, and the
// register offsets inside the upper half of the bus map
////////////////////////////////////////////////////////////

`ifndef ACQ_MACROS_SVH
`define ACQ_MACROS_SVH

// sample RAM address width, 1024 entries
`define ACQ_AW 10
// stream sample width
`define ACQ_DW 16
// system bus data width
`define ACQ_BW 32
// bus address, top bit selects the register half
`define ACQ_BAW (`ACQ_AW + 1)

// register offsets, low address bits of the register half
// command word, start and stop bits
`define ACQ_REG_CTL 0
// post-trigger sample count
`define ACQ_REG_CFG 1
// state and write pointer, read only
`define ACQ_REG_STS 2
// latched trigger pointer, read only
`define ACQ_REG_TRG 3

// status word: lsb of the pointer field
`define ACQ_STS_PTR 16

`endif

//--- verilog/acq_pkg.sv
////////////////////////////////////////////////////////////
// acquisition buffer types
// capture FSM state and the two views of a bus write word
////////////////////////////////////////////////////////////

`include "acq_macros.svh"

package acq_pkg;

  // capture FSM states, read back through status bits 1:0
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_armed = 2'd1,
    st_post  = 2'd2,
    st_done  = 2'd3
  } acq_state_t;

  // bus write word
  // cmd view for the command register
  // cfg view for the post-trigger count register
  typedef union packed {
    struct packed {
      logic [`ACQ_BW-3:0] rsvd;
      // return to idle
      logic               stop;
      // clear pointer and arm
      logic               start;
    } cmd;
    struct packed {
      logic [`ACQ_BW-`ACQ_AW-1:0] rsvd;
      // samples kept after the trigger, 0 acts as 1
      logic [`ACQ_AW-1:0]         cnt;
    } cfg;
  } acq_reg_u;

endpackage

//--- verilog/acq_fsm.sv
////////////////////////////////////////////////////////////
// capture state machine
// idle -> armed on start, armed -> post on trigger,
// post -> done at the end of the post-trigger count
////////////////////////////////////////////////////////////

`include "acq_macros.svh"

module acq_fsm import acq_pkg::*; (
  input  logic       bus,
  input  logic       ctl_rst,
  // command pulses from the register block
  input  logic       start_cmd,
  input  logic       stop_cmd,
  // external trigger strobe
  input  logic       trg,
  // last post-trigger sample written
  input  logic       post_end,
  output acq_state_t state,
  output logic       cap_en,
  output logic       trg_acc,
  output logic       done
);

acq_state_t state_nxt;

////////////////////////////////////////////////////////////
// state register
////////////////////////////////////////////////////////////

always_ff @(posedge bus) begin
  if (ctl_rst) begin
    state <= st_idle;
  end else begin
    state <= state_nxt;
  end
end

// stop beats start, start beats trigger, trigger beats post_end
always_comb begin
  state_nxt = state;
  if (stop_cmd) begin
    state_nxt = st_idle;
  end else if (start_cmd) begin
    state_nxt = st_armed;
  end else begin
    case (state)
      st_armed: begin
        // a count of one ends on the trigger sample itself
        if (trg) begin
          state_nxt = post_end ? st_done : st_post;
        end
      end
      st_post: begin
        if (post_end) begin
          state_nxt = st_done;
        end
      end
      default: begin
        state_nxt = state;
      end
    endcase
  end
end

////////////////////////////////////////////////////////////
// outputs decoded from the registered state
////////////////////////////////////////////////////////////

// samples are stored in armed and post
assign cap_en  = (state == st_armed) | (state == st_post);
// trigger only counts when no command overrides it
assign trg_acc = (state == st_armed) & trg & ~stop_cmd & ~start_cmd;
assign done    = (state == st_done);

// counter ends only inside post, or on the trigger sample
assert property (@(posedge bus) disable iff (ctl_rst)
  post_end |-> (state == st_post) || trg_acc);

endmodule

//--- verilog/acq_post_counter.sv
////////////////////////////////////////////////////////////
// post-trigger countdown
// counts written samples from the trigger on, pulses
// post_end on the sample that takes the count to zero
////////////////////////////////////////////////////////////

`include "acq_macros.svh"

module acq_post_counter (
  input  logic              bus,
  input  logic              ctl_rst,
  // configured count
  input  logic [`ACQ_AW-1:0] post_len,
  // accepted trigger, loads the counter
  input  logic              trg_acc,
  // written-sample strobe
  input  logic              wr_en,
  output logic              post_end
);

logic [`ACQ_AW-1:0] cnt;
logic               busy;
logic [`ACQ_AW-1:0] load_val;

// zero behaves like one sample
assign load_val = (post_len == '0) ? `ACQ_AW'(1) : post_len;

// trigger sample is the last one when the count is one
assign post_end = (trg_acc & wr_en & (load_val == `ACQ_AW'(1)))
                | (~trg_acc & busy & wr_en & (cnt == `ACQ_AW'(1)));

always_ff @(posedge bus) begin
  if (ctl_rst) begin
    cnt  <= '0;
    busy <= 1'b0;
  end else if (trg_acc) begin
    // trigger sample counts if it was written
    cnt  <= wr_en ? load_val - `ACQ_AW'(1) : load_val;
    busy <= ~(wr_en & (load_val == `ACQ_AW'(1)));
  end else if (busy & wr_en) begin
    cnt <= cnt - `ACQ_AW'(1);
    if (cnt == `ACQ_AW'(1)) begin
      busy <= 1'b0;
    end
  end
end

// busy always means at least one sample left
assert property (@(posedge bus) disable iff (ctl_rst)
  busy |-> (cnt != '0));

endmodule

//--- verilog/str_to_ram.sv
////////////////////////////////////////////////////////////
// circular sample RAM
// stream writes at a wrapping pointer while capture is on,
// the bus reads with one cycle of latency
////////////////////////////////////////////////////////////

`include "acq_macros.svh"

module str_to_ram (
  input  logic               bus,
  input  logic               ctl_rst,
  // start pulse, restarts the pointer
  input  logic               clr,
  // stream input, no back-pressure
  input  logic [`ACQ_DW-1:0] str_tdata,
  input  logic               str_tvalid,
  input  logic               cap_en,
  input  logic               trg_acc,
  // bus read port
  input  logic               rd_en,
  input  logic [`ACQ_AW-1:0] rd_addr,
  output logic               wr_en,
  output logic [`ACQ_AW-1:0] wr_ptr,
  output logic [`ACQ_AW-1:0] trg_ptr,
  output logic [`ACQ_DW-1:0] rd_data
);

logic [`ACQ_DW-1:0] buf_mem [0:2**`ACQ_AW-1];

////////////////////////////////////////////////////////////
// stream write
////////////////////////////////////////////////////////////

// samples outside capture are dropped
assign wr_en = str_tvalid & cap_en;

// pointer wraps by its width
always_ff @(posedge bus) begin
  if (ctl_rst | clr) begin
    wr_ptr <= '0;
  end else if (wr_en) begin
    wr_ptr <= wr_ptr + `ACQ_AW'(1);
  end
end

always_ff @(posedge bus) begin
  if (wr_en) begin
    buf_mem[wr_ptr] <= str_tdata;
  end
end

// address of the trigger sample
always_ff @(posedge bus) begin
  if (ctl_rst) begin
    trg_ptr <= '0;
  end else if (trg_acc) begin
    trg_ptr <= wr_ptr;
  end
end

////////////////////////////////////////////////////////////
// bus read
////////////////////////////////////////////////////////////

always_ff @(posedge bus) begin
  if (rd_en) begin
    rd_data <= buf_mem[rd_addr];
  end
end

// pointer holds outside capture unless restarted
assert property (@(posedge bus) disable iff (ctl_rst)
  (!cap_en && !clr) |=> $stable(wr_ptr));

endmodule

//--- verilog/acq_regs.sv
////////////////////////////////////////////////////////////
// system bus decoder
// command, config, status and trigger-pointer registers
// in the upper half, sample RAM reads in the lower half
////////////////////////////////////////////////////////////

`include "acq_macros.svh"

module acq_regs import acq_pkg::*; (
  input  logic                bus,
  input  logic                ctl_rst,
  // system bus
  input  logic [`ACQ_BAW-1:0] addr,
  input  logic                wen,
  input  logic                ren,
  input  acq_reg_u            wdata,
  output logic [`ACQ_BW-1:0]  rdata,
  output logic                ack,
  output logic                err,
  // status sources
  input  acq_state_t          state,
  input  logic [`ACQ_AW-1:0]  wr_ptr,
  input  logic [`ACQ_AW-1:0]  trg_ptr,
  input  logic [`ACQ_DW-1:0]  ram_rdata,
  // control outputs
  output logic                start_cmd,
  output logic                stop_cmd,
  output logic [`ACQ_AW-1:0]  post_len,
  // sample RAM read port
  output logic                ram_ren,
  output logic [`ACQ_AW-1:0]  ram_raddr
);

logic               is_reg;
logic [`ACQ_AW-1:0] off;
logic               ctl_hit, cfg_hit, sts_hit, trg_hit;
logic               acc_bad;
// registered read select, lines up with ack
logic               rd_ram_q, rd_cfg_q, rd_sts_q, rd_trg_q;

////////////////////////////////////////////////////////////
// address decode
////////////////////////////////////////////////////////////

assign is_reg  = addr[`ACQ_BAW-1];
assign off     = addr[`ACQ_AW-1:0];
assign ctl_hit = is_reg & (off == `ACQ_AW'(`ACQ_REG_CTL));
assign cfg_hit = is_reg & (off == `ACQ_AW'(`ACQ_REG_CFG));
assign sts_hit = is_reg & (off == `ACQ_AW'(`ACQ_REG_STS));
assign trg_hit = is_reg & (off == `ACQ_AW'(`ACQ_REG_TRG));

// RAM is read only, status and trigger pointer too
// anything past the last offset is unmapped
assign acc_bad = is_reg ? ~(ctl_hit | cfg_hit | sts_hit | trg_hit)
                          | (wen & (sts_hit | trg_hit))
                        : wen;

// command pulses act on the write edge
assign start_cmd = wen & ctl_hit & wdata.cmd.start;
assign stop_cmd  = wen & ctl_hit & wdata.cmd.stop;

assign ram_ren   = ren & ~is_reg;
assign ram_raddr = off;

////////////////////////////////////////////////////////////
// registers and bus handshake
////////////////////////////////////////////////////////////

always_ff @(posedge bus) begin
  if (ctl_rst) begin
    post_len <= '0;
  end else if (wen & cfg_hit) begin
    post_len <= wdata.cfg.cnt;
  end
end

always_ff @(posedge bus) begin
  if (ctl_rst) begin
    ack      <= 1'b0;
    err      <= 1'b0;
    rd_ram_q <= 1'b0;
    rd_cfg_q <= 1'b0;
    rd_sts_q <= 1'b0;
    rd_trg_q <= 1'b0;
  end else begin
    ack      <= ren | wen;
    err      <= (ren | wen) & acc_bad;
    rd_ram_q <= ram_ren;
    rd_cfg_q <= ren & cfg_hit;
    rd_sts_q <= ren & sts_hit;
    rd_trg_q <= ren & trg_hit;
  end
end

// read mux, zero for command and unmapped reads
always_comb begin
  rdata = '0;
  if (rd_ram_q) begin
    rdata = {{(`ACQ_BW-`ACQ_DW){1'b0}}, ram_rdata};
  end else if (rd_cfg_q) begin
    rdata = {{(`ACQ_BW-`ACQ_AW){1'b0}}, post_len};
  end else if (rd_sts_q) begin
    // pointer in the upper field, state in bits 1:0
    rdata = {{(`ACQ_BW-`ACQ_STS_PTR-`ACQ_AW){1'b0}}, wr_ptr,
             {(`ACQ_STS_PTR-2){1'b0}}, state};
  end else if (rd_trg_q) begin
    rdata = {{(`ACQ_BW-`ACQ_AW){1'b0}}, trg_ptr};
  end
end

// one ack per strobe, never stretched
assert property (@(posedge bus) disable iff (ctl_rst)
  (ack && !(ren || wen)) |=> !ack);

endmodule

//--- verilog/acq_top.sv
////////////////////////////////////////////////////////////
// acquisition buffer top level
// capture FSM, post-trigger counter, sample RAM and bus
// registers on one clock
////////////////////////////////////////////////////////////

`include "acq_macros.svh"

module acq_top import acq_pkg::*; (
  input  logic                bus,
  input  logic                ctl_rst,
  // sample stream
  input  logic [`ACQ_DW-1:0]  str_tdata,
  input  logic                str_tvalid,
  // trigger strobe
  input  logic                trg,
  // system bus
  input  logic [`ACQ_BAW-1:0] addr,
  input  logic                wen,
  input  logic                ren,
  input  logic [`ACQ_BW-1:0]  wdata,
  output logic [`ACQ_BW-1:0]  rdata,
  output logic                ack,
  output logic                err,
  // capture finished
  output logic                done
);

// control between the blocks
logic               start_cmd, stop_cmd;
logic               cap_en, trg_acc, post_end;
acq_state_t         state;
logic [`ACQ_AW-1:0] post_len;
// buffer side
logic               wr_en;
logic [`ACQ_AW-1:0] wr_ptr, trg_ptr;
logic               ram_ren;
logic [`ACQ_AW-1:0] ram_raddr;
logic [`ACQ_DW-1:0] ram_rdata;

acq_fsm u_fsm (
  .bus(bus), .ctl_rst(ctl_rst),
  .start_cmd(start_cmd), .stop_cmd(stop_cmd),
  .trg(trg), .post_end(post_end),
  .state(state), .cap_en(cap_en), .trg_acc(trg_acc), .done(done)
);

acq_post_counter u_cnt (
  .bus(bus), .ctl_rst(ctl_rst),
  .post_len(post_len), .trg_acc(trg_acc), .wr_en(wr_en),
  .post_end(post_end)
);

// start pulse restarts the write pointer
str_to_ram u_buf (
  .bus(bus), .ctl_rst(ctl_rst), .clr(start_cmd),
  .str_tdata(str_tdata), .str_tvalid(str_tvalid),
  .cap_en(cap_en), .trg_acc(trg_acc),
  .rd_en(ram_ren), .rd_addr(ram_raddr),
  .wr_en(wr_en), .wr_ptr(wr_ptr), .trg_ptr(trg_ptr), .rd_data(ram_rdata)
);

acq_regs u_regs (
  .bus(bus), .ctl_rst(ctl_rst),
  .addr(addr), .wen(wen), .ren(ren), .wdata(wdata),
  .rdata(rdata), .ack(ack), .err(err),
  .state(state), .wr_ptr(wr_ptr), .trg_ptr(trg_ptr), .ram_rdata(ram_rdata),
  .start_cmd(start_cmd), .stop_cmd(stop_cmd), .post_len(post_len),
  .ram_ren(ram_ren), .ram_raddr(ram_raddr)
);

endmodule

//--- testbench/acq_tb.sv
////////////////////////////////////////////////////////////
// acquisition buffer testbench
// LFSR samples into the stream, bus tasks for the regs,
// assertions check bus timing and read-back values
////////////////////////////////////////////////////////////

`include "acq_macros.svh"

module acq_tb import acq_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

logic                bus;
logic                ctl_rst;
logic [`ACQ_DW-1:0]  str_tdata;
logic                str_tvalid;
logic                trg;
logic [`ACQ_BAW-1:0] addr;
logic                wen;
logic                ren;
logic [`ACQ_BW-1:0]  wdata;
logic [`ACQ_BW-1:0]  rdata;
logic                ack;
logic                err;
logic                done;

// post-trigger count under test
localparam int POST_LEN = 7;

// reference model of the capture
logic [15:0]        lfsr_state;
logic [`ACQ_DW-1:0] sb [0:2**`ACQ_AW-1];
acq_state_t         model_st;
logic [`ACQ_AW-1:0] model_ptr;
logic [`ACQ_AW-1:0] trg_exp;
int                 post_left;
logic [`ACQ_BW-1:0] rd_word;

acq_top UUT (
  .bus(bus), .ctl_rst(ctl_rst),
  .str_tdata(str_tdata), .str_tvalid(str_tvalid), .trg(trg),
  .addr(addr), .wen(wen), .ren(ren), .wdata(wdata),
  .rdata(rdata), .ack(ack), .err(err), .done(done)
);

// 100 ns period
always #50 bus = ~bus;

////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////

task automatic abort_run();
  $display("*** FAILED ***");
  $fatal(1, "run stopped at the first error");
endtask

// one bit per LFSR step, taps 16 14 13 11
function automatic logic rand_bit();
  logic out;
  out = lfsr_state[15];
  lfsr_state = {lfsr_state[14:0],
                lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
  return out;
endfunction

function automatic logic [`ACQ_DW-1:0] rand_sample();
  logic [`ACQ_DW-1:0] s;
  for (int i = 0; i < `ACQ_DW; i++) begin
    s = {s[`ACQ_DW-2:0], rand_bit()};
  end
  return s;
endfunction

function automatic logic [`ACQ_BAW-1:0] reg_addr(input int off);
  return {1'b1, `ACQ_AW'(off)};
endfunction

// status layout: pointer from bit 16, state in 1:0
function automatic logic [`ACQ_BW-1:0] sts_word(input acq_state_t s,
                                                input logic [`ACQ_AW-1:0] p);
  return (`ACQ_BW'(p) << `ACQ_STS_PTR) | `ACQ_BW'(s);
endfunction

// drive point, 5 ns after the rising edge
task automatic next_cycle();
  @(posedge bus);
  #5;
endtask

task automatic expect_word(input string name, input logic [`ACQ_BW-1:0] exp,
                           input logic [`ACQ_BW-1:0] act);
  assert (act === exp) else begin
    $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic wait_ack();
  int n;
  n = 0;
  while (!ack) begin
    if (n == 20) begin
      $display("no bus ack within 20 cycles of the strobe");
      abort_run();
    end
    next_cycle();
    n++;
  end
endtask

////////////////////////////////////////////////////////////
// bus and stream tasks
////////////////////////////////////////////////////////////

task automatic bus_write(input logic [`ACQ_BAW-1:0] a, input logic [`ACQ_BW-1:0] d,
                         input logic exp_err);
  addr  = a;
  wdata = d;
  wen   = 1'b1;
  next_cycle();
  wen = 1'b0;
  wait_ack();
  expect_word("err", `ACQ_BW'(exp_err), `ACQ_BW'(err));
endtask

task automatic bus_read(input logic [`ACQ_BAW-1:0] a, input logic exp_err,
                        output logic [`ACQ_BW-1:0] d);
  addr = a;
  ren  = 1'b1;
  next_cycle();
  ren = 1'b0;
  wait_ack();
  expect_word("err", `ACQ_BW'(exp_err), `ACQ_BW'(err));
  d = rdata;
endtask

// one stream cycle, the model tracks what should be stored
task automatic push_sample(input logic with_trg);
  logic [`ACQ_DW-1:0] d;
  logic               b0;
  logic               b1;
  logic               v;
  d  = rand_sample();
  b0 = rand_bit();
  b1 = rand_bit();
  // roughly three valid cycles in four, trigger cycle always valid
  v = with_trg | b0 | b1;
  str_tdata  = d;
  str_tvalid = v;
  trg        = with_trg;
  if (with_trg && model_st == st_armed) begin
    trg_exp   = model_ptr;
    model_st  = st_post;
    post_left = (POST_LEN == 0) ? 1 : POST_LEN;
  end
  if (v && (model_st == st_armed || model_st == st_post)) begin
    sb[model_ptr] = d;
    model_ptr++;
    if (model_st == st_post) begin
      post_left--;
      if (post_left == 0) begin
        model_st = st_done;
      end
    end
  end
  next_cycle();
  str_tvalid = 1'b0;
  trg        = 1'b0;
endtask

task automatic check_status();
  bus_read(reg_addr(`ACQ_REG_STS), 1'b0, rd_word);
  expect_word("status", sts_word(model_st, model_ptr), rd_word);
endtask

task automatic check_ram();
  for (int i = 0; i < int'(model_ptr); i++) begin
    bus_read({1'b0, `ACQ_AW'(i)}, 1'b0, rd_word);
    expect_word($sformatf("ram[%0d]", i), `ACQ_BW'(sb[i]), rd_word);
  end
endtask

////////////////////////////////////////////////////////////
// bus timing assertions
////////////////////////////////////////////////////////////

// one ack, one cycle after every strobe
assert property (@(posedge bus) disable iff (ctl_rst) (ren || wen) |=> ack)
  else begin
    $display("[FAIL] %0t ns ack expected 1 got %b", $time, $sampled(ack));
    abort_run();
  end

assert property (@(posedge bus) disable iff (ctl_rst) ack |-> $past(ren || wen))
  else begin
    $display("[FAIL] %0t ns ack expected 0 got %b", $time, $sampled(ack));
    abort_run();
  end

assert property (@(posedge bus) disable iff (ctl_rst) err |-> ack)
  else begin
    $display("err high without ack at %0t ns", $time);
    abort_run();
  end

// RAM and read-only registers refuse writes, unmapped offsets refuse all
assert property (@(posedge bus) disable iff (ctl_rst)
  ((wen && !addr[`ACQ_BAW-1])
   || (wen && addr[`ACQ_BAW-1] && addr[`ACQ_AW-1:0] >= `ACQ_REG_STS)
   || ((ren || wen) && addr[`ACQ_BAW-1] && addr[`ACQ_AW-1:0] > `ACQ_REG_TRG))
  |=> err)
  else begin
    $display("[FAIL] %0t ns err expected 1 got %b", $time, $sampled(err));
    abort_run();
  end

// mapped reads and control writes are clean
assert property (@(posedge bus) disable iff (ctl_rst)
  ((ren && (!addr[`ACQ_BAW-1] || addr[`ACQ_AW-1:0] <= `ACQ_REG_TRG))
   || (wen && addr[`ACQ_BAW-1] && addr[`ACQ_AW-1:0] <= `ACQ_REG_CFG))
  |=> !err)
  else begin
    $display("[FAIL] %0t ns err expected 0 got %b", $time, $sampled(err));
    abort_run();
  end

////////////////////////////////////////////////////////////
// stimulus
////////////////////////////////////////////////////////////

initial begin
  int n;
  bus        = 1'b0;
  ctl_rst    = 1'b1;
  str_tdata  = '0;
  str_tvalid = 1'b0;
  trg        = 1'b0;
  addr       = '0;
  wen        = 1'b0;
  ren        = 1'b0;
  wdata      = '0;
  lfsr_state = 16'd14053;
  model_st   = st_idle;
  model_ptr  = '0;
  trg_exp    = '0;
  post_left  = 0;
  repeat (3) @(posedge bus);
  #5;
  ctl_rst = 1'b0;

  // config write and read-back
  bus_write(reg_addr(`ACQ_REG_CFG), `ACQ_BW'(POST_LEN), 1'b0);
  bus_read(reg_addr(`ACQ_REG_CFG), 1'b0, rd_word);
  expect_word("post_len", `ACQ_BW'(POST_LEN), rd_word);

  // start, stream a block while armed
  bus_write(reg_addr(`ACQ_REG_CTL), `ACQ_BW'(1), 1'b0);
  model_st  = st_armed;
  model_ptr = '0;
  repeat (24) push_sample(1'b0);
  check_status();
  check_ram();

  // trigger, then run until the DUT reports done
  push_sample(1'b1);
  n = 0;
  while (!done) begin
    if (n == 100) begin
      $display("done never rose after the trigger");
      abort_run();
    end
    push_sample(1'b0);
    n++;
  end
  expect_word("model_state", `ACQ_BW'(st_done), `ACQ_BW'(model_st));
  bus_read(reg_addr(`ACQ_REG_TRG), 1'b0, rd_word);
  expect_word("trg_ptr", `ACQ_BW'(trg_exp), rd_word);
  // pointer stops post_len samples past the trigger sample
  bus_read(reg_addr(`ACQ_REG_STS), 1'b0, rd_word);
  expect_word("final_ptr", `ACQ_BW'(trg_exp + `ACQ_AW'(POST_LEN)),
              `ACQ_BW'(rd_word[`ACQ_STS_PTR +: `ACQ_AW]));
  check_status();
  check_ram();

  // stream after done is dropped
  repeat (10) push_sample(1'b0);
  expect_word("done", `ACQ_BW'(1), `ACQ_BW'(done));
  check_status();
  check_ram();

  // stop, then a trigger in idle changes nothing
  bus_write(reg_addr(`ACQ_REG_CTL), `ACQ_BW'(2), 1'b0);
  model_st = st_idle;
  check_status();
  push_sample(1'b1);
  check_status();
  bus_read(reg_addr(`ACQ_REG_TRG), 1'b0, rd_word);
  expect_word("trg_ptr", `ACQ_BW'(trg_exp), rd_word);

  // refused accesses
  bus_write({1'b0, `ACQ_AW'(5)}, 32'h0000_abcd, 1'b1);
  bus_write(reg_addr(`ACQ_REG_STS), '0, 1'b1);
  bus_write(reg_addr(`ACQ_REG_TRG), '0, 1'b1);
  bus_read(reg_addr(7), 1'b1, rd_word);
  // RAM contents survive the refused write
  check_ram();

  $display("*** PASSED ***");
  $finish;
end

endmodule

//--- vlog.f
+incdir+include
verilog/acq_pkg.sv
verilog/acq_fsm.sv
verilog/acq_post_counter.sv
verilog/str_to_ram.sv
verilog/acq_regs.sv
verilog/acq_top.sv
testbench/acq_tb.sv

//--- Bender.yml
package:
  name: acq_buffer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/acq_pkg.sv
      - verilog/acq_fsm.sv
      - verilog/acq_post_counter.sv
      - verilog/str_to_ram.sv
      - verilog/acq_regs.sv
      - verilog/acq_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/acq_tb.sv
